// File: dv/exInput.txt
# test wait op(dec) | exc rs rt imm16 shamt addrRs addrRt regWriteData tnew | memAddr memData
# wbAddr wbData stall clr | expected aluOut exc regWriteData dataRt tnew (all hex after op)
1 0 1 0 5 7 0 0 1 2 0 2 0 0 0 0 0 0 c 0 c 7 1
2 0 3 0 5 7 0 0 1 2 0 0 0 0 0 0 0 0 fffffffe 0 fffffffe 7 0
3 0 5 0 f0f0ff00 ff00ff0 0 0 1 2 0 0 0 0 0 0 0 0 f00f00 0 f00f00 ff00ff0 0
4 0 6 0 f0f0ff00 ff00ff0 0 0 1 2 0 0 0 0 0 0 0 0 fff0fff0 0 fff0fff0 ff00ff0 0
5 0 7 0 f0f0ff00 ff00ff0 0 0 1 2 0 0 0 0 0 0 0 0 ff00f0f0 0 ff00f0f0 ff00ff0 0
6 0 8 0 f0f0ff00 ff00ff0 0 0 1 2 0 0 0 0 0 0 0 0 f000f 0 f000f ff00ff0 0
7 0 9 0 ffffffff 1 0 0 1 2 0 0 0 0 0 0 0 0 1 0 1 1 0
8 0 10 0 ffffffff 1 0 0 1 2 0 0 0 0 0 0 0 0 0 0 0 1 0
9 0 11 0 0 8000000f 0 4 1 2 0 0 0 0 0 0 0 0 f0 0 f0 8000000f 0
10 0 12 0 0 8000000f 0 4 1 2 0 0 0 0 0 0 0 0 8000000 0 8000000 8000000f 0
11 0 13 0 0 8000000f 0 4 1 2 0 0 0 0 0 0 0 0 f8000000 0 f8000000 8000000f 0
12 0 14 0 24 1 0 0 1 2 0 0 0 0 0 0 0 0 10 0 10 1 0
13 0 15 0 1f 80000000 0 0 1 2 0 0 0 0 0 0 0 0 1 0 1 80000000 0
14 0 16 0 1f 80000000 0 0 1 2 0 0 0 0 0 0 0 0 ffffffff 0 ffffffff 80000000 0
15 0 26 0 0 0 1234 0 1 2 0 0 0 0 0 0 0 0 12340000 0 12340000 0 0
16 0 17 0 ff000000 0 0 0 1 2 0 0 0 0 0 0 0 0 8 0 8 0 0
17 0 18 0 ffff 0 0 0 1 2 0 0 0 0 0 0 0 0 10 0 10 0 0
18 0 19 0 10 0 fffe 0 1 2 0 0 0 0 0 0 0 0 e 0 e 0 0
19 0 20 0 0 0 8000 0 1 2 0 0 0 0 0 0 0 0 ffff8000 0 ffff8000 0 0
20 0 21 0 ffffffff 0 8001 0 1 2 0 0 0 0 0 0 0 0 8001 0 8001 0 0
21 0 23 0 ffff0000 0 ffff 0 1 2 0 0 0 0 0 0 0 0 ffffffff 0 ffffffff 0 0
22 0 24 0 fffffffe 0 ffff 0 1 2 0 0 0 0 0 0 0 0 1 0 1 0 0
23 0 25 0 5 0 ffff 0 1 2 0 0 0 0 0 0 0 0 1 0 1 0 0
24 0 1 0 1 2 0 0 3 4 0 0 3 100 3 200 0 0 102 0 102 2 0
25 0 1 0 1 2 0 0 3 4 0 0 5 99 4 50 0 0 51 0 51 50 0
26 0 1 0 1 2 0 0 0 0 0 0 0 77 0 88 0 0 3 0 3 2 0
27 0 28 0 1000 0 4 0 1 2 dead 0 2 cafe 2 beef 0 0 1004 0 dead cafe 0
28 0 1 0 7fffffff 1 0 0 1 2 0 0 0 0 0 0 0 0 80000000 c 80000000 1 0
29 0 19 0 7fffffff 0 1 0 1 2 0 0 0 0 0 0 0 0 80000000 c 80000000 0 0
30 0 3 0 80000000 1 0 0 1 2 0 0 0 0 0 0 0 0 7fffffff c 7fffffff 1 0
31 0 27 0 7ffffffc 0 4 0 1 2 0 0 0 0 0 0 0 0 80000000 4 0 0 0
32 0 28 0 80000000 0 ffff 0 1 2 0 0 0 0 0 0 0 0 7fffffff 5 0 0 0
33 0 1 a 1 1 0 0 1 2 0 0 0 0 0 0 0 0 2 a 2 1 0
34 0 1 3 7fffffff 1 0 0 1 2 0 0 0 0 0 0 0 0 80000000 3 80000000 1 0
35 0 29 0 fffffffe 3 0 0 1 2 0 0 0 0 0 0 0 0 0 0 0 3 0
36 1 37 0 0 0 0 0 1 2 0 0 0 0 0 0 0 0 ffffffff 0 ffffffff 0 0
37 0 38 0 0 0 0 0 1 2 0 0 0 0 0 0 0 0 fffffffa 0 fffffffa 0 0
38 0 30 0 ffffffff 2 0 0 1 2 0 0 0 0 0 0 0 0 0 0 0 2 0
39 1 37 0 0 0 0 0 1 2 0 0 0 0 0 0 0 0 1 0 1 0 0
40 0 31 0 fffffff9 2 0 0 1 2 0 0 0 0 0 0 0 0 0 0 0 2 0
41 1 38 0 0 0 0 0 1 2 0 0 0 0 0 0 0 0 fffffffd 0 fffffffd 0 0
42 0 37 0 0 0 0 0 1 2 0 0 0 0 0 0 0 0 ffffffff 0 ffffffff 0 0
43 0 32 0 7 0 0 0 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0
44 1 38 0 0 0 0 0 1 2 0 0 0 0 0 0 0 0 fffffffd 0 fffffffd 0 0
45 0 39 0 10 0 0 0 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0
46 0 40 0 20 0 0 0 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0
47 0 33 0 3 4 0 0 1 2 0 0 0 0 0 0 0 0 0 0 0 4 0
48 1 38 0 0 0 0 0 1 2 0 0 0 0 0 0 0 0 2c 0 2c 0 0
49 0 37 0 0 0 0 0 1 2 0 0 0 0 0 0 0 0 10 0 10 0 0
50 0 35 0 1 30 0 0 1 2 0 0 0 0 0 0 0 0 0 0 0 30 0
51 1 38 0 0 0 0 0 1 2 0 0 0 0 0 0 0 0 fffffffc 0 fffffffc 0 0
52 0 37 0 0 0 0 0 1 2 0 0 0 0 0 0 0 0 f 0 f 0 0
53 0 1 0 1 2 0 0 1 2 0 3 0 0 0 0 0 0 3 0 3 2 2
54 0 3 0 9 1 0 0 1 2 0 1 0 0 0 0 1 0 3 0 3 2 2
55 0 1 0 5 5 0 0 1 2 0 0 0 0 0 0 0 1 0 0 0 0 0
56 0 1 0 5 5 0 0 1 2 0 0 0 0 0 0 0 0 a 0 a 5 0
57 0 1 0 1 1 0 0 1 2 0 0 0 0 0 0 1 1 0 0 0 0 0
58 0 27 0 100 0 8 0 1 2 dead 3 0 0 0 0 0 0 108 0 dead 0 2

// File: vlog.f
common/exPkg.sv
verilog/instrClass.sv
verilog/operandForward.sv
verilog/aluUnit.sv
mulDiv/mulDivUnit.sv
verilog/exStage.sv
dv/tbClock.sv
dv/exChecker.sv
dv/exTb.sv

// File: Makefile
# Verilator build and run of the execute stage testbench

SIM := obj_dir/VexTb

.PHONY: all run clean

all: run

$(SIM): vlog.f $(shell cat vlog.f)
	verilator --binary --timing -Wno-fatal --top-module exTb -f vlog.f -o VexTb

run: $(SIM) dv/exInput.txt
	$(SIM) | tee sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/exTb.sv
//********************
// Execute stage testbench
// Replays dv/exInput.txt through the DUT
//********************
`timescale 1ns/100ps
`default_nettype none

module exTb;

    localparam int MULT_CYCLES  = 5;
    localparam int DIV_CYCLES   = 10;
    localparam int IDLE_TIMEOUT = 40;

    logic            clk;
    logic            rst_n;
    logic            stall;
    logic            clr;
    logic            mdDisable;
    logic            mdBusy;
    logic            expValid;
    int              expTest;
    int              testCount;
    int              failedTests;
    int              errorCount;
    int              tbErrors;
    exPkg::exIn_t    exIn;
    exPkg::fwdPort_t fwdMem;
    exPkg::fwdPort_t fwdWb;
    exPkg::exOut_t   exOut;
    exPkg::exOut_t   expOut;

    tbClock tbClock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    exStage #(
        .MULT_CYCLES (MULT_CYCLES),
        .DIV_CYCLES  (DIV_CYCLES)
    ) exStage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .clr       (clr),
        .mdDisable (mdDisable),
        .exIn      (exIn),
        .fwdMem    (fwdMem),
        .fwdWb     (fwdWb),
        .exOut     (exOut),
        .mdBusy    (mdBusy)
    );

    exChecker exChecker_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .expValid    (expValid),
        .expTest     (expTest),
        .expOut      (expOut),
        .exOut       (exOut),
        .instr       (exIn.instr),
        .mdBusy      (mdBusy),
        .testCount   (testCount),
        .failedTests (failedTests),
        .errorCount  (errorCount)
    );

    // Put a bubble in the stage, then wait for the mult/div unit to drain
    task automatic waitForIdle(input int testNum);
        int cycles;
        cycles = 0;
        @(posedge clk);
        exIn     <= '0;
        fwdMem   <= '0;
        fwdWb    <= '0;
        stall    <= 1'b0;
        clr      <= 1'b0;
        expValid <= 1'b0;
        @(negedge clk);
        while (mdBusy && cycles < IDLE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (mdBusy) begin
            $display("mdBusy did not drop within %0d cycles before test %0d",
                     IDLE_TIMEOUT, testNum);
            tbErrors++;
        end
    endtask

    initial begin
        int              fd;
        int              got;
        int              cycles;
        int              testNum;
        int              waitIdle;
        int              op;
        string           line;
        logic [31:0]     col [20];
        exPkg::exIn_t    nextIn;
        exPkg::fwdPort_t nextMem;
        exPkg::fwdPort_t nextWb;
        exPkg::exOut_t   nextExp;

        exIn      = '0;
        fwdMem    = '0;
        fwdWb     = '0;
        stall     = 1'b0;
        clr       = 1'b0;
        mdDisable = 1'b0;
        expValid  = 1'b0;
        expTest   = 0;
        expOut    = '0;
        tbErrors  = 0;

        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 40) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was never released");
            tbErrors++;
        end

        fd = $fopen("dv/exInput.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file dv/exInput.txt");
            tbErrors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            got = $fgets(line, fd);
            if (got == 0 || line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            got = $sscanf(line,
                "%d %d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                testNum, waitIdle, op, col[0], col[1], col[2], col[3], col[4], col[5],
                col[6], col[7], col[8], col[9], col[10], col[11], col[12], col[13],
                col[14], col[15], col[16], col[17], col[18], col[19]);
            if (got != 23) begin
                $display("Malformed vector line: %s", line);
                tbErrors++;
                continue;
            end

            nextIn              = '0;
            nextIn.instr        = exPkg::instr_t'(op[5:0]);
            nextIn.pc           = testNum * 4;
            nextIn.exc          = col[0][4:0];
            nextIn.dataRs       = col[1];
            nextIn.dataRt       = col[2];
            nextIn.imm16        = col[3][15:0];
            nextIn.shamt        = col[4][4:0];
            nextIn.addrRs       = col[5][4:0];
            nextIn.addrRt       = col[6][4:0];
            nextIn.regWriteData = col[7];
            nextIn.tnew         = col[8][exPkg::TNEW_W-1:0];
            nextMem.addr        = col[9][4:0];
            nextMem.data        = col[10];
            nextWb.addr         = col[11][4:0];
            nextWb.data         = col[12];
            nextExp             = '0;
            nextExp.aluOut       = col[15];
            nextExp.exc          = col[16][4:0];
            nextExp.regWriteData = col[17];
            nextExp.dataRt       = col[18];
            nextExp.tnew         = col[19][exPkg::TNEW_W-1:0];

            if (waitIdle != 0) begin
                waitForIdle(testNum);
            end
            @(posedge clk);
            exIn     <= nextIn;
            fwdMem   <= nextMem;
            fwdWb    <= nextWb;
            stall    <= col[13][0];
            clr      <= col[14][0];
            expOut   <= nextExp;
            expTest  <= testNum;
            expValid <= 1'b1;
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        // Flush the last vector through the checker
        @(posedge clk);
        exIn     <= '0;
        stall    <= 1'b0;
        clr      <= 1'b0;
        expValid <= 1'b0;
        @(posedge clk);
        @(posedge clk);

        $display("%0d tests run, %0d failed, %0d errors, %0d testbench errors",
                 testCount, failedTests, errorCount, tbErrors);
        if (errorCount == 0 && tbErrors == 0 && testCount > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Overall limit on the run
    initial begin
        #400000;
        $display("Simulation did not reach the end of the vectors in time");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/exChecker.sv
//********************
// Execute stage checker
// Compares exOut with the expected vector one edge later
//********************
`timescale 1ns/100ps
`default_nettype none

module exChecker (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          expValid,
    input  int            expTest,
    input  exPkg::exOut_t expOut,
    input  exPkg::exOut_t exOut,
    input  exPkg::instr_t instr,
    input  logic          mdBusy,
    output int            testCount,
    output int            failedTests,
    output int            errorCount
);

    logic          pending;
    int            heldTest;
    exPkg::exOut_t heldExp;
    int            mismatches;

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        if (got !== want) begin
            $display("[FAIL] %0t ns test %0d %s: got 0x%08h, expected 0x%08h",
                     $time, heldTest, name, got, want);
            mismatches++;
        end
    endtask

    // Vector driven at edge N is registered by the DUT at edge N+1
    always @(posedge clk) begin
        pending  <= expValid;
        heldTest <= expTest;
        heldExp  <= expOut;
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            testCount   = 0;
            failedTests = 0;
            errorCount  = 0;
        end else begin
            if (pending) begin
                mismatches = 0;
                compareField("exOut.aluOut", exOut.aluOut, heldExp.aluOut);
                compareField("exOut.exc", 32'(exOut.exc), 32'(heldExp.exc));
                compareField("exOut.regWriteData", exOut.regWriteData, heldExp.regWriteData);
                compareField("exOut.dataRt", exOut.dataRt, heldExp.dataRt);
                compareField("exOut.tnew", 32'(exOut.tnew), 32'(heldExp.tnew));
                testCount++;
                errorCount += mismatches;
                if (mismatches != 0) begin
                    failedTests++;
                end
                $display("test %0d: %s", heldTest, (mismatches == 0) ? "ok" : "mismatch");
            end
            // A start opcode on the inputs must raise busy in the same cycle
            if (instr inside {exPkg::MULT, exPkg::MULTU, exPkg::DIV, exPkg::DIVU,
                              exPkg::MADD, exPkg::MADDU, exPkg::MSUB, exPkg::MSUBU}
                && mdBusy !== 1'b1) begin
                $display("[FAIL] %0t ns mdBusy: got %b, expected 1 for %s start",
                         $time, mdBusy, instr.name());
                errorCount++;
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tbClock.sv
//********************
// Testbench clock and reset
// 20 ns clock, reset low for 16 cycles
//********************
`timescale 1ns/100ps
`default_nettype none

module tbClock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: verilog/exStage.sv
//********************
// Execute stage top
// Forwarding, ALU, mult/div and the memory-stage register
//********************
`timescale 1ns/100ps
`default_nettype none

module exStage #(
    parameter int MULT_CYCLES = 5,
    parameter int DIV_CYCLES  = 10
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            clr,
    input  logic            mdDisable,
    input  exPkg::exIn_t    exIn,
    input  exPkg::fwdPort_t fwdMem,
    input  exPkg::fwdPort_t fwdWb,
    output exPkg::exOut_t   exOut,
    output logic            mdBusy
);

    exPkg::func_t  func;
    exPkg::exOut_t exNext;
    logic [31:0]   srcRs;
    logic [31:0]   srcRt;
    logic [31:0]   aluResult;
    logic [4:0]    aluExc;
    logic [31:0]   mdResult;
    logic          isMoveFrom;
    logic          writesResult;
    logic [31:0]   stageResult;

    instrClass instrClass_i (
        .instr (exIn.instr),
        .func  (func)
    );

    operandForward operandForward_i (
        .addrRs (exIn.addrRs),
        .addrRt (exIn.addrRt),
        .dataRs (exIn.dataRs),
        .dataRt (exIn.dataRt),
        .fwdMem (fwdMem),
        .fwdWb  (fwdWb),
        .srcRs  (srcRs),
        .srcRt  (srcRt)
    );

    aluUnit aluUnit_i (
        .instr  (exIn.instr),
        .func   (func),
        .dataRs (srcRs),
        .dataRt (srcRt),
        .imm16  (exIn.imm16),
        .shamt  (exIn.shamt),
        .result (aluResult),
        .exc    (aluExc)
    );

    mulDivUnit #(
        .MULT_CYCLES (MULT_CYCLES),
        .DIV_CYCLES  (DIV_CYCLES)
    ) mulDivUnit_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .instr  (exIn.instr),
        .enable (~mdDisable),
        .dataRs (srcRs),
        .dataRt (srcRt),
        .busy   (mdBusy),
        .result (mdResult)
    );

    assign isMoveFrom   = (exIn.instr == exPkg::MFHI) || (exIn.instr == exPkg::MFLO);
    assign writesResult = isMoveFrom || (func == exPkg::FUNC_CALC_R) ||
                          (func == exPkg::FUNC_CALC_I);
    assign stageResult  = isMoveFrom ? mdResult : aluResult;

    always_comb begin
        exNext.instr        = exIn.instr;
        exNext.pc           = exIn.pc;
        // Earlier stage exception takes precedence
        exNext.exc          = (exIn.exc != 5'd0) ? exIn.exc : aluExc;
        exNext.bd           = exIn.bd;
        exNext.aluOut       = stageResult;
        exNext.addrRt       = exIn.addrRt;
        exNext.dataRt       = srcRt;
        exNext.addrRd       = exIn.addrRd;
        exNext.regWriteAddr = exIn.regWriteAddr;
        exNext.regWriteData = writesResult ? stageResult : exIn.regWriteData;
        exNext.tnew         = (exIn.tnew != '0) ? exIn.tnew - 1'b1 : '0;
    end

    // Clear wins over stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exOut <= '0;
        end else if (clr) begin
            exOut <= '0;
        end else if (!stall) begin
            exOut <= exNext;
        end
    end

endmodule

`default_nettype wire

// File: mulDiv/mulDivUnit.sv
//********************
// Multiply/divide unit
// HI/LO registers with a latency countdown
//********************
`timescale 1ns/100ps
`default_nettype none

module mulDivUnit #(
    parameter int MULT_CYCLES = 5,
    parameter int DIV_CYCLES  = 10
) (
    input  logic          clk,
    input  logic          rst_n,
    input  exPkg::instr_t instr,
    input  logic          enable,
    input  logic [31:0]   dataRs,
    input  logic [31:0]   dataRt,
    output logic          busy,
    output logic [31:0]   result
);

    localparam int MAX_CYCLES = (MULT_CYCLES > DIV_CYCLES) ? MULT_CYCLES : DIV_CYCLES;
    localparam int CNT_W      = $clog2(MAX_CYCLES + 1);

    logic [CNT_W-1:0] countdown;
    logic [31:0]      hi;
    logic [31:0]      lo;
    logic             isMult;
    logic             isDiv;
    logic             isMadd;
    logic             isMsub;
    logic             isUnsigned;
    logic             idleGo;
    logic [63:0]      extRs;
    logic [63:0]      extRt;
    logic [63:0]      product;
    logic [31:0]      divisor;
    logic [31:0]      quotient;
    logic [31:0]      remainder;

    assign isMult     = instr inside {exPkg::MULT, exPkg::MULTU};
    assign isDiv      = instr inside {exPkg::DIV, exPkg::DIVU};
    assign isMadd     = instr inside {exPkg::MADD, exPkg::MADDU};
    assign isMsub     = instr inside {exPkg::MSUB, exPkg::MSUBU};
    assign isUnsigned = instr inside {exPkg::MULTU, exPkg::DIVU, exPkg::MADDU, exPkg::MSUBU};

    // Busy also covers the cycle a start opcode sits in the stage
    assign busy   = (countdown != '0) || isMult || isDiv || isMadd || isMsub;
    assign idleGo = enable && (countdown == '0);

    assign extRs   = isUnsigned ? {32'b0, dataRs} : {{32{dataRs[31]}}, dataRs};
    assign extRt   = isUnsigned ? {32'b0, dataRt} : {{32{dataRt[31]}}, dataRt};
    assign product = extRs * extRt;

    // Divider input stays defined for a zero divisor that never commits
    assign divisor   = (dataRt == 32'b0) ? 32'd1 : dataRt;
    assign quotient  = isUnsigned ? dataRs / divisor : 32'($signed(dataRs) / $signed(divisor));
    assign remainder = isUnsigned ? dataRs % divisor : 32'($signed(dataRs) % $signed(divisor));

    assign result = busy                  ? 32'b0 :
                    (instr == exPkg::MFHI) ? hi :
                    (instr == exPkg::MFLO) ? lo : 32'b0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hi        <= '0;
            lo        <= '0;
            countdown <= '0;
        end else if (countdown != '0) begin
            countdown <= countdown - 1'b1;
        end else if (idleGo) begin
            if (isMult) begin
                {hi, lo}  <= product;
                countdown <= CNT_W'(MULT_CYCLES);
            end else if (isDiv && dataRt != 32'b0) begin
                hi        <= remainder;
                lo        <= quotient;
                countdown <= CNT_W'(DIV_CYCLES);
            end else if (isMadd) begin
                {hi, lo}  <= {hi, lo} + product;
                countdown <= CNT_W'(MULT_CYCLES);
            end else if (isMsub) begin
                {hi, lo}  <= {hi, lo} - product;
                countdown <= CNT_W'(MULT_CYCLES);
            end else if (instr == exPkg::MTHI) begin
                hi <= dataRs;
            end else if (instr == exPkg::MTLO) begin
                lo <= dataRs;
            end
        end
    end

    countdownBound: assert property (@(posedge clk) disable iff (!rst_n)
        countdown <= CNT_W'(DIV_CYCLES));

    // Results are final at the start edge and stay put during the countdown
    hiloFrozen: assert property (@(posedge clk) disable iff (!rst_n)
        (countdown != '0) |=> $stable({hi, lo}));

endmodule

`default_nettype wire

// File: verilog/aluUnit.sv
//********************
// Execute stage ALU
// Operand select, arithmetic, logic, shifts and exceptions
//********************
`timescale 1ns/100ps
`default_nettype none

module aluUnit (
    input  exPkg::instr_t instr,
    input  exPkg::func_t  func,
    input  logic [31:0]   dataRs,
    input  logic [31:0]   dataRt,
    input  logic [15:0]   imm16,
    input  logic [4:0]    shamt,
    output logic [31:0]   result,
    output logic [4:0]    exc
);

    logic        zeroExt;
    logic        isMem;
    logic [31:0] extImm;
    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [32:0] sum33;
    logic [32:0] diff33;
    logic        ovfAdd;
    logic        ovfSub;

    // Count leading bits equal to val from bit 31 down
    function automatic logic [31:0] countLeading(input logic [31:0] word, input logic val);
        logic [31:0] count;
        logic        stop;
        count = '0;
        stop  = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (!stop && word[i] == val) begin
                count = count + 32'd1;
            end else begin
                stop = 1'b1;
            end
        end
        return count;
    endfunction

    assign isMem   = (func == exPkg::FUNC_MEM_READ) || (func == exPkg::FUNC_MEM_WRITE);
    // Logical immediates are zero-extended
    assign zeroExt = instr inside {exPkg::ANDI, exPkg::ORI, exPkg::XORI, exPkg::LUI};
    assign extImm  = zeroExt ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};

    assign srcA = (instr inside {exPkg::SLL, exPkg::SRL, exPkg::SRA}) ? {27'b0, shamt} : dataRs;
    assign srcB = (func == exPkg::FUNC_CALC_I || isMem) ? extImm :
                  (func == exPkg::FUNC_CALC_R)          ? dataRt : 32'b0;

    // One extra sign bit exposes signed overflow
    assign sum33  = {srcA[31], srcA} + {srcB[31], srcB};
    assign diff33 = {srcA[31], srcA} - {srcB[31], srcB};
    assign ovfAdd = sum33[32] ^ sum33[31];
    assign ovfSub = diff33[32] ^ diff33[31];

    always_comb begin
        result = '0;
        if (isMem) begin
            result = sum33[31:0];
        end else begin
            case (instr)
                exPkg::ADD, exPkg::ADDU, exPkg::ADDI, exPkg::ADDIU: result = sum33[31:0];
                exPkg::SUB, exPkg::SUBU: result = diff33[31:0];
                exPkg::AND, exPkg::ANDI: result = srcA & srcB;
                exPkg::OR, exPkg::ORI: result = srcA | srcB;
                exPkg::XOR, exPkg::XORI: result = srcA ^ srcB;
                exPkg::NOR: result = ~(srcA | srcB);
                exPkg::SLT, exPkg::SLTI: result = {31'b0, $signed(srcA) < $signed(srcB)};
                exPkg::SLTU, exPkg::SLTIU: result = {31'b0, srcA < srcB};
                exPkg::SLL, exPkg::SLLV: result = srcB << srcA[4:0];
                exPkg::SRL, exPkg::SRLV: result = srcB >> srcA[4:0];
                exPkg::SRA, exPkg::SRAV: result = 32'($signed(srcB) >>> srcA[4:0]);
                exPkg::LUI: result = {srcB[15:0], 16'b0};
                exPkg::CLO: result = countLeading(srcA, 1'b1);
                exPkg::CLZ: result = countLeading(srcA, 1'b0);
                default: result = '0;
            endcase
        end
    end

    always_comb begin
        exc = '0;
        if (func == exPkg::FUNC_MEM_READ && ovfAdd) begin
            exc = exPkg::EXC_ADEL;
        end else if (func == exPkg::FUNC_MEM_WRITE && ovfAdd) begin
            exc = exPkg::EXC_ADES;
        end else if ((instr == exPkg::ADD || instr == exPkg::ADDI) && ovfAdd) begin
            exc = exPkg::EXC_OV;
        end else if (instr == exPkg::SUB && ovfSub) begin
            exc = exPkg::EXC_OV;
        end
    end

    // Class from the decoder must agree with the trapping opcodes
    always_comb begin
        assert final (exc == 5'd0 ||
                      instr inside {exPkg::ADD, exPkg::ADDI, exPkg::SUB, exPkg::LW, exPkg::SW})
            else $error("aluUnit: exception 0x%0h raised for %s", exc, instr.name());
    end

endmodule

`default_nettype wire

// File: verilog/operandForward.sv
//********************
// Operand forwarding
// Memory stage first, then write-back, then decode value
//********************
`timescale 1ns/100ps
`default_nettype none

module operandForward (
    input  logic [4:0]      addrRs,
    input  logic [4:0]      addrRt,
    input  logic [31:0]     dataRs,
    input  logic [31:0]     dataRt,
    input  exPkg::fwdPort_t fwdMem,
    input  exPkg::fwdPort_t fwdWb,
    output logic [31:0]     srcRs,
    output logic [31:0]     srcRt
);

    // Register zero is hard-wired and never forwarded
    function automatic logic [31:0] pick(input logic [4:0] addr, input logic [31:0] data,
                                         input exPkg::fwdPort_t mem, input exPkg::fwdPort_t wb);
        if (mem.addr == addr && mem.addr != 5'd0) begin
            return mem.data;
        end else if (wb.addr == addr && wb.addr != 5'd0) begin
            return wb.data;
        end
        return data;
    endfunction

    assign srcRs = pick(addrRs, dataRs, fwdMem, fwdWb);
    assign srcRt = pick(addrRt, dataRt, fwdMem, fwdWb);

endmodule

`default_nettype wire

// File: verilog/instrClass.sv
//********************
// Instruction classifier
// Maps a decoded opcode to its function class
//********************
`timescale 1ns/100ps
`default_nettype none

module instrClass (
    input  exPkg::instr_t instr,
    output exPkg::func_t  func
);

    always_comb begin
        case (instr)
            exPkg::ADD, exPkg::ADDU, exPkg::SUB, exPkg::SUBU,
            exPkg::AND, exPkg::OR, exPkg::XOR, exPkg::NOR,
            exPkg::SLT, exPkg::SLTU,
            exPkg::SLL, exPkg::SRL, exPkg::SRA,
            exPkg::SLLV, exPkg::SRLV, exPkg::SRAV,
            exPkg::CLO, exPkg::CLZ:
                func = exPkg::FUNC_CALC_R;
            exPkg::ADDI, exPkg::ADDIU, exPkg::ANDI, exPkg::ORI,
            exPkg::XORI, exPkg::SLTI, exPkg::SLTIU, exPkg::LUI:
                func = exPkg::FUNC_CALC_I;
            exPkg::LW:
                func = exPkg::FUNC_MEM_READ;
            exPkg::SW:
                func = exPkg::FUNC_MEM_WRITE;
            // Moves to and from HI/LO belong to the mult/div unit too
            exPkg::MULT, exPkg::MULTU, exPkg::DIV, exPkg::DIVU,
            exPkg::MADD, exPkg::MADDU, exPkg::MSUB, exPkg::MSUBU,
            exPkg::MFHI, exPkg::MFLO, exPkg::MTHI, exPkg::MTLO:
                func = exPkg::FUNC_MULDIV;
            default:
                func = exPkg::FUNC_OTHER;
        endcase
    end

endmodule

`default_nettype wire

// File: common/exPkg.sv
//********************
// Execute stage package
// Opcodes, function classes, exception codes and stage structs
//********************
`default_nettype none

package exPkg;

    // Decoded opcode identifiers
    // NOP stays at zero so a cleared register reads as a bubble
    typedef enum logic [5:0] {
        NOP   = 6'd0,
        ADD   = 6'd1,  ADDU  = 6'd2,  SUB   = 6'd3,  SUBU  = 6'd4,
        AND   = 6'd5,  OR    = 6'd6,  XOR   = 6'd7,  NOR   = 6'd8,
        SLT   = 6'd9,  SLTU  = 6'd10,
        SLL   = 6'd11, SRL   = 6'd12, SRA   = 6'd13,
        SLLV  = 6'd14, SRLV  = 6'd15, SRAV  = 6'd16,
        CLO   = 6'd17, CLZ   = 6'd18,
        ADDI  = 6'd19, ADDIU = 6'd20, ANDI  = 6'd21, ORI   = 6'd22,
        XORI  = 6'd23, SLTI  = 6'd24, SLTIU = 6'd25, LUI   = 6'd26,
        LW    = 6'd27, SW    = 6'd28,
        MULT  = 6'd29, MULTU = 6'd30, DIV   = 6'd31, DIVU  = 6'd32,
        MADD  = 6'd33, MADDU = 6'd34, MSUB  = 6'd35, MSUBU = 6'd36,
        MFHI  = 6'd37, MFLO  = 6'd38, MTHI  = 6'd39, MTLO  = 6'd40
    } instr_t;

    typedef enum logic [2:0] {
        FUNC_CALC_R    = 3'd0,
        FUNC_CALC_I    = 3'd1,
        FUNC_MEM_READ  = 3'd2,
        FUNC_MEM_WRITE = 3'd3,
        FUNC_MULDIV    = 3'd4,
        FUNC_OTHER     = 3'd5
    } func_t;

    // Exception codes where zero means none
    localparam logic [4:0] EXC_ADEL = 5'd4;
    localparam logic [4:0] EXC_ADES = 5'd5;
    localparam logic [4:0] EXC_OV   = 5'd12;

    localparam int TNEW_W = 2;

    // Decode to execute register
    typedef struct packed {
        instr_t             instr;
        logic [31:0]        pc;
        logic [4:0]         exc;
        logic               bd;
        logic [31:0]        dataRs;
        logic [31:0]        dataRt;
        logic [15:0]        imm16;
        logic [4:0]         shamt;
        logic [4:0]         addrRs;
        logic [4:0]         addrRt;
        logic [4:0]         addrRd;
        logic [4:0]         regWriteAddr;
        logic [31:0]        regWriteData;
        logic [TNEW_W-1:0]  tnew;
    } exIn_t;

    // Execute to memory register
    typedef struct packed {
        instr_t             instr;
        logic [31:0]        pc;
        logic [4:0]         exc;
        logic               bd;
        logic [31:0]        aluOut;
        logic [4:0]         addrRt;
        logic [31:0]        dataRt;
        logic [4:0]         addrRd;
        logic [4:0]         regWriteAddr;
        logic [31:0]        regWriteData;
        logic [TNEW_W-1:0]  tnew;
    } exOut_t;

    // One register write-back target used as a forward source
    typedef struct packed {
        logic [4:0]  addr;
        logic [31:0] data;
    } fwdPort_t;

endpackage

`default_nettype wire
